// File: src.f
mem_access_pkg.sv
addr_translate.sv
mem_exc_check.sv
ll_link_reg.sv
store_lane_gen.sv
load_lane_gen.sv
mem1_access.sv
tb_mem1_access.sv

// File: run.sh
#!/bin/sh
# build and run the mem1_access testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mem1_access -f src.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_mem1_access)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'SIMULATION PASSED'; then
    exit 0
fi
exit 1

// File: tb_mem1_access.sv
`timescale 1ns/1ps

module tb_mem1_access;
    import mem_access_pkg::*;

    localparam int N_RAND = 16;
    // reset, translation, stores, loads, exceptions, LL/SC, flush
    localparam int TEST_CYCLES = 10 + 3 * N_RAND + 20 + 28 + 15 + 7 + 1;

    logic     clk;
    logic     arst_n;
    mem_req_t req;
    addr_t    pc;
    tlb_res_t tlb;
    up_exc_t  up_exc;
    logic     interrupt;
    logic     eret_flush;
    cattr_t   config_k0;
    exc_out_t exc_out;
    dm_req_t  dm_req;

    integer seed = 32'h3a9b7481;
    int     errors = 0;
    int     checks = 0;
    addr_t  link_va;  // address of the last LL issued

    mem1_access dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .pc        (pc),
        .tlb       (tlb),
        .up_exc    (up_exc),
        .interrupt (interrupt),
        .eret_flush(eret_flush),
        .config_k0 (config_k0),
        .exc_out   (exc_out),
        .dm_req    (dm_req)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog
    initial begin
        #((TEST_CYCLES + 200) * 10);
        $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES + 200);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // inputs change on the rising edge and outputs are read at the falling edge
    task automatic drive(input mem_req_t r, input tlb_res_t t, input up_exc_t u, input logic irq,
                         input logic flush, input cattr_t k0, input addr_t p);
        @(posedge clk);
        req        <= r;
        tlb        <= t;
        up_exc     <= u;
        interrupt  <= irq;
        eret_flush <= flush;
        config_k0  <= k0;
        pc         <= p;
        @(negedge clk);
    endtask

    function automatic mem_req_t make_req(input dm_sel_t sel, input addr_t va, input word_t rt);
        mem_req_t r;
        r       = '0;
        r.en    = 1'b1;
        r.wr    = (sel <= SEL_SWR);  // store kinds come first
        r.rd    = ~r.wr;
        r.rf_wr = ~r.wr;
        r.sel   = sel;
        r.vaddr = va;
        r.rt    = rt;
        return r;
    endfunction

    function automatic tlb_res_t valid_tlb();
        tlb_res_t t;
        t       = '0;
        t.found = 1'b1;
        t.v     = 1'b1;
        t.d     = 1'b1;
        t.c     = CATTR_CACHED;
        return t;
    endfunction

    function automatic addr_t exp_paddr(input addr_t va, input pfn_t pfn);
        if (!va[31] || va[30]) begin
            return {pfn, va[11:0]};  // kuseg, kseg2, kseg3
        end
        return {3'b000, va[28:0]};
    endfunction

    function automatic logic exp_cached(input addr_t va, input cattr_t k0, input cattr_t c);
        if (va[31:29] == 3'b100) begin
            return (k0 == CATTR_CACHED);
        end
        if (va[31:29] == 3'b101) begin
            return 1'b0;
        end
        return (c == CATTR_CACHED);
    endfunction

    function automatic logic [3:0] exp_wstrb(input dm_sel_t sel, input logic [1:0] off);
        logic [4:0] m;
        m = (5'b00010 << off) - 5'd1;  // ones from byte 0 through off
        case (sel)
            SEL_SB:  return 4'b0001 << off;
            SEL_SH:  return off[1] ? 4'b1100 : 4'b0011;
            SEL_SWL: return m[3:0];
            SEL_SWR: return 4'b1111 << off;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic word_t exp_wdata(input dm_sel_t sel, input logic [1:0] off, input word_t rt);
        int n;
        n = 3 - int'(off);
        case (sel)
            SEL_SB:  return {rt[7:0], rt[7:0], rt[7:0], rt[7:0]};
            SEL_SH:  return {rt[15:0], rt[15:0]};
            SEL_SWL: return rt >> (8 * n);
            SEL_SWR: return rt << (8 * int'(off));
            default: return rt;
        endcase
    endfunction

    function automatic rstrb_t exp_rstrb(input dm_sel_t sel, input logic [1:0] off);
        logic [2:0] grow;
        logic [3:0] shrink;
        grow   = 3'b111 << (2'd3 - off);
        shrink = 4'b1111 >> off;
        case (sel)
            SEL_LBU: return {3'b000, off};
            SEL_LB:  return {3'b010, off};
            SEL_LHU: return {3'b001, off[1], 1'b0};
            SEL_LH:  return {3'b011, off[1], 1'b0};
            SEL_LWL: return {2'b11, grow};
            SEL_LWR: return {1'b1, shrink};
            default: return 5'b11111;
        endcase
    endfunction

    function automatic size_t exp_size(input dm_sel_t sel);
        if (sel == SEL_SB || sel == SEL_LBU || sel == SEL_LB) begin
            return SIZE_BYTE;
        end
        if (sel == SEL_SH || sel == SEL_LHU || sel == SEL_LH) begin
            return SIZE_HALF;
        end
        return SIZE_WORD;
    endfunction

    task automatic test_translate();
        word_t    rnd;
        addr_t    va;
        tlb_res_t t;
        cattr_t   k0;
        logic     cached;
        for (int i = 0; i < 3 * N_RAND; i++) begin
            rnd = $random(seed);
            case (i % 3)
                0:       va = {3'b100, rnd[28:2], 2'b00};
                1:       va = {3'b101, rnd[28:2], 2'b00};
                default: va = (i % 2 == 0) ? {1'b0, rnd[30:2], 2'b00} : {2'b11, rnd[29:2], 2'b00};
            endcase
            rnd   = $random(seed);
            t     = valid_tlb();
            t.pfn = rnd[31:12];
            t.c   = (i % 4 < 2) ? CATTR_CACHED : rnd[2:0];
            k0    = (i % 4 == 1 || i % 4 == 2) ? CATTR_CACHED : rnd[6:4];
            drive(make_req(SEL_LW, va, 32'h0), t, '0, 1'b0, 1'b0, k0, 32'h0);
            cached = exp_cached(va, k0, t.c);
            check("paddr", dm_req.paddr, exp_paddr(va, t.pfn));
            check("dcache_valid", 32'(dm_req.dcache_valid), 32'(cached));
            check("uncache_valid", 32'(dm_req.uncache_valid), 32'(!cached));
        end
    endtask

    task automatic test_lanes(input int first, input int last);
        word_t   rnd;
        word_t   rt;
        addr_t   va;
        dm_sel_t sel;
        for (int s = first; s <= last; s++) begin
            for (int off = 0; off < 4; off++) begin
                sel = 4'(s);
                rt  = $random(seed);
                rnd = $random(seed);
                va  = {3'b100, rnd[28:2], 2'(off)};  // kseg0 needs no TLB
                drive(make_req(sel, va, rt), valid_tlb(), '0, 1'b0, 1'b0, CATTR_CACHED, 32'h0);
                if (sel <= SEL_SWR) begin
                    check("wstrb", 32'(dm_req.wstrb), 32'(exp_wstrb(sel, 2'(off))));
                    check("wdata", dm_req.wdata, exp_wdata(sel, 2'(off), rt));
                end else begin
                    check("rstrb", 32'(dm_req.rstrb), 32'(exp_rstrb(sel, 2'(off))));
                end
                check("size", 32'(dm_req.size), 32'(exp_size(sel)));
            end
        end
    endtask

    task automatic test_misaligned();
        word_t      rnd;
        addr_t      va;
        dm_sel_t    sel;
        logic [1:0] off;
        exc_code_t  code;
        for (int c = 0; c < 4; c++) begin
            case (c)
                0: begin
                    sel  = SEL_SH;
                    off  = 2'd1;
                    code = EXC_ADES;
                end
                1: begin
                    sel  = SEL_SW;
                    off  = 2'd2;
                    code = EXC_ADES;
                end
                2: begin
                    sel  = SEL_LH;
                    off  = 2'd3;
                    code = EXC_ADEL;
                end
                default: begin
                    sel  = SEL_LW;
                    off  = 2'd1;
                    code = EXC_ADEL;
                end
            endcase
            rnd = $random(seed);
            va  = {3'b100, rnd[28:2], off};
            drive(make_req(sel, va, rnd), valid_tlb(), '0, 1'b0, 1'b0, CATTR_CACHED, 32'h0);
            check("exception", 32'(exc_out.exception), 32'h1);
            check("code", 32'(exc_out.code), 32'(code));
            check("badvaddr", exc_out.badvaddr, va);
        end
    endtask

    task automatic test_tlb();
        word_t     rnd;
        addr_t     va;
        tlb_res_t  t;
        mem_req_t  r;
        logic      hit;
        logic      fault;
        exc_code_t code;
        for (int c = 0; c < 5; c++) begin
            rnd   = $random(seed);
            va    = {1'b0, rnd[30:2], 2'b00};  // kuseg
            t     = '0;
            t.pfn = rnd[31:12];
            r     = make_req((c < 2) ? SEL_LW : SEL_SW, va, rnd);
            case (c)
                1: t.found = 1'b1;  // invalid entry
                3: begin            // clean page
                    t.found = 1'b1;
                    t.v     = 1'b1;
                end
                4: t = valid_tlb();
                default: ;          // miss
            endcase
            hit   = t.found & t.v;
            fault = !hit || (r.wr && !t.d);
            code  = !hit ? (r.wr ? EXC_TLBS : EXC_TLBL) : EXC_MOD;
            drive(r, t, '0, 1'b0, 1'b0, CATTR_CACHED, 32'h0);
            check("exception", 32'(exc_out.exception), 32'(fault));
            if (fault) begin
                check("code", 32'(exc_out.code), 32'(code));
                check("badvaddr", exc_out.badvaddr, va);
            end
            check("tlb_exc", 32'(exc_out.tlb_exc), 32'(fault));
            check("tlbrill", 32'(exc_out.tlbrill), 32'(!t.found));
        end
    endtask

    // sources drop out one by one from the highest
    task automatic test_priority();
        word_t      rnd;
        addr_t      va;
        addr_t      pcv;
        logic [1:0] lo;
        up_exc_t    u;
        logic       irq;
        exc_code_t  code;
        addr_t      bad;
        rnd = $random(seed);
        pcv = $random(seed);
        for (int k = 0; k < 6; k++) begin
            lo         = (k <= 4) ? 2'b01 : 2'b00;
            va         = {1'b0, rnd[30:2], lo};  // mapped and missing in the TLB
            irq        = (k == 0);
            u          = '0;
            u.exc      = (k <= 1);
            u.code     = EXC_CPU;
            u.overflow = (k <= 2);
            u.trap     = (k <= 3);
            drive(make_req(SEL_SW, va, rnd), '0, u, irq, 1'b0, CATTR_CACHED, pcv);
            if (irq) begin
                code = EXC_INT;
                bad  = '0;
            end else if (u.exc) begin
                code = u.code;
                bad  = pcv;
            end else if (u.overflow) begin
                code = EXC_OV;
                bad  = '0;
            end else if (u.trap) begin
                code = EXC_TRAP;
                bad  = '0;
            end else if (lo != 2'b00) begin
                code = EXC_ADES;
                bad  = va;
            end else begin
                code = EXC_TLBS;
                bad  = va;
            end
            check("exception", 32'(exc_out.exception), 32'h1);
            check("code", 32'(exc_out.code), 32'(code));
            check("badvaddr", exc_out.badvaddr, bad);
            check("tlb_exc", 32'(exc_out.tlb_exc), 32'(!u.exc));
            check("tlbrill", 32'(exc_out.tlbrill), 32'(!u.exc));
            check("cause_ce_wr", 32'(exc_out.cause_ce_wr), 32'(code == EXC_CPU));
        end
    endtask

    function automatic mem_req_t ll_req(input addr_t va);
        mem_req_t r;
        r    = make_req(SEL_LW, va, 32'h0);
        r.ll = 1'b1;
        return r;
    endfunction

    function automatic mem_req_t sc_req(input addr_t va);
        mem_req_t r;
        r    = make_req(SEL_SW, va, 32'h5a5a_0ff0);
        r.sc = 1'b1;
        return r;
    endfunction

    task automatic run_sc(input addr_t va, input logic ok);
        drive(sc_req(va), valid_tlb(), '0, 1'b0, 1'b0, CATTR_CACHED, 32'h0);
        check("dcache_valid", 32'(dm_req.dcache_valid), 32'(ok));
        check("uncache_valid", 32'(dm_req.uncache_valid), 32'h0);
        check("dm_en", 32'(dm_req.dm_en), 32'(ok));
        check("wen", 32'(dm_req.wen), 32'(ok));
        check("sc_out", 32'(dm_req.sc_out), 32'(ok));
    endtask

    task automatic test_ll_sc();
        word_t rnd;
        rnd     = $random(seed);
        link_va = {3'b100, rnd[28:2], 2'b00};
        run_sc(link_va, 1'b0);  // no LL seen since reset
        drive(ll_req(link_va), valid_tlb(), '0, 1'b0, 1'b0, CATTR_CACHED, 32'h0);
        run_sc(link_va, 1'b1);
        run_sc(link_va ^ 32'h10, 1'b0);
        drive(ll_req(link_va), valid_tlb(), '0, 1'b0, 1'b0, CATTR_CACHED, 32'h0);
        drive('0, valid_tlb(), '0, 1'b1, 1'b0, CATTR_CACHED, 32'h0);  // interrupt
        check("ee", 32'(exc_out.ee), 32'h1);
        run_sc(link_va, 1'b0);
    endtask

    task automatic test_flush();
        word_t rnd;
        addr_t va;
        rnd = $random(seed);
        va  = {3'b100, rnd[28:2], 2'b00};
        drive(make_req(SEL_LW, va, 32'h0), valid_tlb(), '0, 1'b0, 1'b1, CATTR_CACHED, 32'h0);
        check("ee", 32'(exc_out.ee), 32'h1);
        check("exception", 32'(exc_out.exception), 32'h0);
        check("dm_en", 32'(dm_req.dm_en), 32'h0);
        check("dcache_valid", 32'(dm_req.dcache_valid),
              32'(exp_cached(va, CATTR_CACHED, CATTR_CACHED)));
    endtask

    initial begin
        arst_n     = 1'b0;
        req        = '0;
        pc         = '0;
        tlb        = '0;
        up_exc     = '0;
        interrupt  = 1'b0;
        eret_flush = 1'b0;
        config_k0  = CATTR_CACHED;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        test_ll_sc();         // runs first while the link is still clear
        test_translate();
        test_lanes(0, 4);     // stores
        test_lanes(5, 11);    // loads
        test_misaligned();
        test_tlb();
        test_priority();
        test_flush();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: mem1_access.sv
`timescale 1ns/1ps

module mem1_access (
    input  logic                     clk,
    input  logic                     arst_n,
    input  mem_access_pkg::mem_req_t req,
    input  mem_access_pkg::addr_t    pc,
    input  mem_access_pkg::tlb_res_t tlb,
    input  mem_access_pkg::up_exc_t  up_exc,
    input  logic                     interrupt,
    input  logic                     eret_flush,
    input  mem_access_pkg::cattr_t   config_k0,
    output mem_access_pkg::exc_out_t exc_out,
    output mem_access_pkg::dm_req_t  dm_req
);
    import mem_access_pkg::*;

    addr_t paddr;
    logic  mapped;
    logic  uncached;
    logic  sc_ok;
    logic  sc_gate;
    logic  wen;
    logic  dcache_valid;
    logic  uncache_valid;

    addr_translate u_xlate (
        .vaddr    (req.vaddr),
        .en       (req.en),
        .tlb      (tlb),
        .config_k0(config_k0),
        .paddr    (paddr),
        .mapped   (mapped),
        .uncached (uncached)
    );

    mem_exc_check u_exc (
        .req       (req),
        .vaddr_pc  (pc),
        .mapped    (mapped),
        .tlb       (tlb),
        .wen       (wen),
        .up_exc    (up_exc),
        .interrupt (interrupt),
        .eret_flush(eret_flush),
        .exc_out   (exc_out)
    );

    // LL reservation lives next to the request gating it steers
    ll_link_reg u_link (
        .clk   (clk),
        .arst_n(arst_n),
        .ll    (req.ll),
        .sc    (req.sc),
        .vaddr (req.vaddr),
        .ee    (exc_out.ee),
        .sc_ok (sc_ok)
    );

    assign sc_gate = ~req.sc | sc_ok;  // failed SC kills the access

    assign wen           = req.wr & sc_gate;
    assign dcache_valid  = req.en & sc_gate & ~uncached;
    assign uncache_valid = req.en & sc_gate & uncached;

    store_lane_gen u_st (
        .sel     (req.sel),
        .byte_off(paddr[1:0]),
        .rt      (req.rt),
        .wstrb   (dm_req.wstrb),
        .wdata   (dm_req.wdata)
    );

    load_lane_gen u_ld (
        .sel     (req.sel),
        .byte_off(paddr[1:0]),
        .rstrb   (dm_req.rstrb),
        .size    (dm_req.size)
    );

    assign dm_req.dcache_valid  = dcache_valid;
    assign dm_req.uncache_valid = uncache_valid;
    assign dm_req.dm_en         = req.en & sc_gate & ~exc_out.ee;
    assign dm_req.wen           = wen;
    assign dm_req.paddr         = paddr;
    assign dm_req.sc_out        = dcache_valid | uncache_valid;  // SC result bit

endmodule

// File: load_lane_gen.sv
`timescale 1ns/1ps

module load_lane_gen (
    input  mem_access_pkg::dm_sel_t sel,
    input  logic [1:0]              byte_off,
    output mem_access_pkg::rstrb_t  rstrb,
    output mem_access_pkg::size_t   size
);
    import mem_access_pkg::*;

    always_comb begin
        case (sel)
            SEL_LBU: rstrb = {3'b000, byte_off};
            SEL_LB:  rstrb = {3'b010, byte_off};        // sign extend
            SEL_LHU: rstrb = {3'b001, byte_off[1], 1'b0};
            SEL_LH:  rstrb = {3'b011, byte_off[1], 1'b0};
            SEL_LWL: begin
                case (byte_off)  // fill grows with offset
                    2'd0:    rstrb = 5'b11000;
                    2'd1:    rstrb = 5'b11100;
                    2'd2:    rstrb = 5'b11110;
                    default: rstrb = 5'b11111;
                endcase
            end
            SEL_LWR: begin
                case (byte_off)  // fill shrinks with offset
                    2'd0:    rstrb = 5'b11111;
                    2'd1:    rstrb = 5'b10111;
                    2'd2:    rstrb = 5'b10011;
                    default: rstrb = 5'b10001;
                endcase
            end
            default: rstrb = 5'b11111;  // LW, LL and stores
        endcase
    end

    always_comb begin
        case (sel)
            SEL_SB, SEL_LBU, SEL_LB: size = SIZE_BYTE;
            SEL_SH, SEL_LHU, SEL_LH: size = SIZE_HALF;
            default:                 size = SIZE_WORD;
        endcase
    end

endmodule

// File: store_lane_gen.sv
`timescale 1ns/1ps

module store_lane_gen (
    input  mem_access_pkg::dm_sel_t sel,
    input  logic [1:0]              byte_off,
    input  mem_access_pkg::word_t   rt,
    output logic [3:0]              wstrb,
    output mem_access_pkg::word_t   wdata
);
    import mem_access_pkg::*;

    logic [4:0] shamt_l;  // SWL right shift
    logic [4:0] shamt_r;  // SWR left shift

    assign shamt_l = {2'b11 - byte_off, 3'b000};
    assign shamt_r = {byte_off, 3'b000};

    always_comb begin
        case (sel)
            SEL_SB: begin
                wstrb = 4'b0001 << byte_off;
            end
            SEL_SH: begin
                wstrb = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            SEL_SWL: begin
                case (byte_off)  // bytes 0 up to offset
                    2'd0:    wstrb = 4'b0001;
                    2'd1:    wstrb = 4'b0011;
                    2'd2:    wstrb = 4'b0111;
                    default: wstrb = 4'b1111;
                endcase
            end
            SEL_SWR: begin
                case (byte_off)  // offset up to byte 3
                    2'd0:    wstrb = 4'b1111;
                    2'd1:    wstrb = 4'b1110;
                    2'd2:    wstrb = 4'b1100;
                    default: wstrb = 4'b1000;
                endcase
            end
            default: begin
                wstrb = 4'b1111;  // SW, SC
            end
        endcase
    end

    always_comb begin
        case (sel)
            SEL_SB:  wdata = {4{rt[7:0]}};
            SEL_SH:  wdata = {2{rt[15:0]}};
            SEL_SWL: wdata = rt >> shamt_l;  // msb side lands at offset
            SEL_SWR: wdata = rt << shamt_r;
            default: wdata = rt;
        endcase
    end

endmodule

// File: ll_link_reg.sv
`timescale 1ns/1ps

module ll_link_reg (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  ll,
    input  logic                  sc,
    input  mem_access_pkg::addr_t vaddr,
    input  logic                  ee,
    output logic                  sc_ok
);
    import mem_access_pkg::*;

    logic  ll_bit;
    addr_t ll_addr;

    // any flush drops the reservation, even on the LL itself
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ll_bit  <= 1'b0;
            ll_addr <= '0;
        end else if (ee) begin
            ll_bit  <= 1'b0;
            ll_addr <= '0;
        end else if (ll) begin
            ll_bit  <= 1'b1;
            ll_addr <= vaddr;   // linked address
        end
    end

    assign sc_ok = sc & ll_bit & (ll_addr == vaddr);

endmodule

// File: mem_exc_check.sv
`timescale 1ns/1ps

module mem_exc_check (
    input  mem_access_pkg::mem_req_t req,
    input  mem_access_pkg::addr_t    vaddr_pc,
    input  logic                     mapped,
    input  mem_access_pkg::tlb_res_t tlb,
    input  logic                     wen,
    input  mem_access_pkg::up_exc_t  up_exc,
    input  logic                     interrupt,
    input  logic                     eret_flush,
    output mem_access_pkg::exc_out_t exc_out
);
    import mem_access_pkg::*;

    logic      ades;
    logic      adel;
    logic      tlb_hit;
    logic      tlbl;
    logic      tlbs;
    logic      tlbmod;
    logic      tlb_cond;
    logic      refill;
    exc_code_t tlb_code;
    exc_code_t code;
    addr_t     badvaddr;

    // misaligned halfword and word accesses
    assign ades = req.wr &
                  (((req.sel == SEL_SW) && (req.vaddr[1:0] != 2'b00)) ||
                   ((req.sel == SEL_SH) && req.vaddr[0]));
    assign adel = req.rf_wr & req.rd &
                  (((req.sel == SEL_LW) && (req.vaddr[1:0] != 2'b00)) ||
                   (((req.sel == SEL_LHU) || (req.sel == SEL_LH)) && req.vaddr[0]));

    assign tlb_hit = tlb.found & tlb.v;

    assign tlbl   = mapped & ~tlb_hit & ~wen;  // miss or invalid on load
    assign tlbs   = mapped & ~tlb_hit & wen;
    assign tlbmod = mapped & wen & tlb_hit & ~tlb.d;  // clean page write

    assign tlb_cond = tlbl | tlbs | tlbmod;
    assign refill   = mapped & ~tlb.found & ~up_exc.exc;

    always_comb begin
        if (tlbl) begin
            tlb_code = EXC_TLBL;
        end else if (tlbs) begin
            tlb_code = EXC_TLBS;
        end else begin
            tlb_code = EXC_MOD;
        end
    end

    // first match wins
    always_comb begin
        if (interrupt) begin
            code     = EXC_INT;
            badvaddr = '0;
        end else if (up_exc.exc) begin
            code     = up_exc.code;
            badvaddr = vaddr_pc;  // earlier stage faults report the PC
        end else if (up_exc.overflow) begin
            code     = EXC_OV;
            badvaddr = '0;
        end else if (up_exc.trap) begin
            code     = EXC_TRAP;
            badvaddr = '0;
        end else if (ades) begin
            code     = EXC_ADES;
            badvaddr = req.vaddr;
        end else if (adel) begin
            code     = EXC_ADEL;
            badvaddr = req.vaddr;
        end else begin
            code     = tlb_code;
            badvaddr = req.vaddr;
        end
    end

    always_comb begin
        exc_out.exception = tlb_cond | interrupt | up_exc.overflow | up_exc.trap |
                            ades | adel | up_exc.exc;
        exc_out.ee          = exc_out.exception | eret_flush;
        exc_out.code        = code;
        exc_out.badvaddr    = badvaddr;
        exc_out.tlb_exc     = (tlb_cond & ~up_exc.exc) | up_exc.tlb_exc;
        exc_out.tlbrill     = refill | up_exc.tlbrill;
        exc_out.cause_ce_wr = (code == EXC_CPU);
    end

endmodule

// File: addr_translate.sv
`timescale 1ns/1ps

module addr_translate (
    input  mem_access_pkg::addr_t    vaddr,
    input  logic                     en,
    input  mem_access_pkg::tlb_res_t tlb,
    input  mem_access_pkg::cattr_t   config_k0,
    output mem_access_pkg::addr_t    paddr,
    output logic                     mapped,
    output logic                     uncached
);
    import mem_access_pkg::*;

    logic kseg0;
    logic kseg1;
    logic k0_cached;
    logic tlb_cached;

    assign kseg0 = (vaddr[31:29] == 3'b100);
    assign kseg1 = (vaddr[31:29] == 3'b101);

    // kuseg, kseg2 and kseg3 go through the TLB
    assign mapped = en & (~vaddr[31] | (vaddr[31] & vaddr[30]));

    always_comb begin
        if (mapped) begin
            paddr = {tlb.pfn, vaddr[11:0]};  // frame + page offset
        end else begin
            paddr = {3'b000, vaddr[28:0]};   // direct segment map
        end
    end

    // kseg1 is never cached
    assign k0_cached  = kseg0 & (config_k0 == CATTR_CACHED);
    assign tlb_cached = ~kseg0 & ~kseg1 & (tlb.c == CATTR_CACHED);

    assign uncached = ~(k0_cached | tlb_cached);

endmodule

// File: mem_access_pkg.sv
package mem_access_pkg;

    typedef logic [31:0] addr_t;   // byte address, virtual or physical
    typedef logic [31:0] word_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;
    typedef logic [3:0]  dm_sel_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [4:0]  rstrb_t;  // {word, sign/mode, half, off[1:0]}
    typedef logic [2:0]  size_t;

    localparam cattr_t CATTR_CACHED = 3'd3;

    // store kinds
    localparam dm_sel_t SEL_SB  = 4'd0;
    localparam dm_sel_t SEL_SH  = 4'd1;
    localparam dm_sel_t SEL_SW  = 4'd2;   // also SC
    localparam dm_sel_t SEL_SWL = 4'd3;
    localparam dm_sel_t SEL_SWR = 4'd4;
    // load kinds
    localparam dm_sel_t SEL_LBU = 4'd5;
    localparam dm_sel_t SEL_LB  = 4'd6;
    localparam dm_sel_t SEL_LHU = 4'd7;
    localparam dm_sel_t SEL_LH  = 4'd8;
    localparam dm_sel_t SEL_LWL = 4'd9;
    localparam dm_sel_t SEL_LWR = 4'd10;
    localparam dm_sel_t SEL_LW  = 4'd11;  // also LL

    localparam exc_code_t EXC_INT  = 5'd0;
    localparam exc_code_t EXC_MOD  = 5'd1;
    localparam exc_code_t EXC_TLBL = 5'd2;
    localparam exc_code_t EXC_TLBS = 5'd3;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;
    localparam exc_code_t EXC_CPU  = 5'd11;
    localparam exc_code_t EXC_OV   = 5'd12;
    localparam exc_code_t EXC_TRAP = 5'd13;

    localparam size_t SIZE_BYTE = 3'd0;
    localparam size_t SIZE_HALF = 3'd1;
    localparam size_t SIZE_WORD = 3'd2;

    typedef struct packed {
        logic    en;      // load or store in MEM1
        logic    wr;
        logic    rd;
        logic    rf_wr;
        dm_sel_t sel;
        logic    ll;
        logic    sc;
        addr_t   vaddr;
        word_t   rt;
    } mem_req_t;

    typedef struct packed {
        logic   found;
        logic   v;
        logic   d;
        pfn_t   pfn;
        cattr_t c;
    } tlb_res_t;

    typedef struct packed {
        logic      exc;
        exc_code_t code;
        logic      tlb_exc;
        logic      tlbrill;
        logic      overflow;
        logic      trap;
    } up_exc_t;

    typedef struct packed {
        logic      exception;
        logic      ee;          // flush
        exc_code_t code;
        addr_t     badvaddr;
        logic      tlb_exc;
        logic      tlbrill;
        logic      cause_ce_wr;
    } exc_out_t;

    typedef struct packed {
        logic       dcache_valid;
        logic       uncache_valid;
        logic       dm_en;
        logic       wen;
        addr_t      paddr;
        logic [3:0] wstrb;
        word_t      wdata;
        rstrb_t     rstrb;
        size_t      size;
        logic       sc_out;
    } dm_req_t;

endpackage
